/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = exe_core_tb
FLIST = flist.f

SRCS = $(shell grep -v '^+' $(FLIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100

clean:
	rm -rf obj_dir

/* bench/exe_core_sva.sv */
module exe_core_sva #(
    parameter exe_pkg::word_t reset_pc = 32'hbfc00000
) (
    input logic               clk,
    input logic               resetn,
    input logic               stall,
    input logic               flush,
    input exe_pkg::id_ex_t    id_in,
    input exe_pkg::fwd_sel_e  forward_a,
    input exe_pkg::fwd_sel_e  forward_b,
    input exe_pkg::word_t     result_w,
    input exe_pkg::ex_mem_t   ex_mem,
    input exe_pkg::dword_t    hilo,
    input logic               busy
);

    int errors = 0;

    exe_pkg::id_ex_t  cur;
    exe_pkg::id_ex_t  bubble;
    logic [5:0]       dcnt;
    exe_pkg::ex_mem_t exp_q;
    exe_pkg::dword_t  hilo_q;
    exe_pkg::dword_t  hilo_nxt;
    exe_pkg::ex_mem_t nxt;
    exe_pkg::word_t   a;
    exe_pkg::word_t   fb;
    exe_pkg::word_t   b;
    logic             is_div;
    logic             rdy;
    logic             hold;
    logic             ovf;
    logic             hl_wr;

    //////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////

    function automatic exe_pkg::word_t calc_result(input exe_pkg::alu_op_e op,
            input exe_pkg::word_t x, input exe_pkg::word_t y, input exe_pkg::reg_addr_t sa,
            input exe_pkg::word_t pc, input exe_pkg::dword_t hl);
        case (op)
            exe_pkg::and_op: return x & y;
            exe_pkg::or_op:  return x | y;
            exe_pkg::xor_op: return x ^ y;
            exe_pkg::nor_op: return ~(x | y);
            exe_pkg::lui:    return {y[15:0], 16'h0000};
            exe_pkg::sll:    return y << sa;
            exe_pkg::srl:    return y >> sa;
            exe_pkg::sra:    return $signed(y) >>> sa;
            exe_pkg::sllv:   return y << x[4:0];
            exe_pkg::srlv:   return y >> x[4:0];
            exe_pkg::srav:   return $signed(y) >>> x[4:0];
            exe_pkg::add, exe_pkg::addu: return x + y;
            exe_pkg::sub, exe_pkg::subu: return x - y;
            exe_pkg::slt:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            exe_pkg::sltu:   return (x < y) ? 32'd1 : 32'd0;
            exe_pkg::mfhi:   return hl[63:32];
            exe_pkg::mflo:   return hl[31:0];
            exe_pkg::link:   return pc + 32'd8;
            default:         return 32'd0;
        endcase
    endfunction

    // true sum out of the signed 32-bit range
    function automatic logic calc_ovf(input exe_pkg::alu_op_e op,
            input exe_pkg::word_t x, input exe_pkg::word_t y);
        longint sx;
        longint sy;
        longint s;
        sx = $signed(x);
        sy = $signed(y);
        if (op == exe_pkg::add) begin
            s = sx + sy;
        end else if (op == exe_pkg::sub) begin
            s = sx - sy;
        end else begin
            return 1'b0;
        end
        return (s > 64'sd2147483647) || (s < -64'sd2147483648);
    endfunction

    // remainder in hi and quotient in lo
    function automatic exe_pkg::dword_t calc_div(input logic sgn,
            input exe_pkg::word_t n, input exe_pkg::word_t d);
        longint sn;
        longint sd;
        longint q;
        longint r;
        if (d == 32'd0) begin
            return {n, 32'hffffffff};
        end
        if (sgn) begin
            sn = $signed(n);
            sd = $signed(d);
        end else begin
            sn = {32'd0, n};
            sd = {32'd0, d};
        end
        q = sn / sd;
        r = sn % sd;
        return {r[31:0], q[31:0]};
    endfunction

    //////////////////////////////////////////////////
    // stage model
    //////////////////////////////////////////////////

    always_comb begin
        longint pa;
        longint pb;
        bubble    = '0;
        bubble.pc = reset_pc;
        is_div = (cur.alu_op == exe_pkg::div) || (cur.alu_op == exe_pkg::divu);
        // ready cycle comes 33 edges after the divide was loaded
        rdy  = is_div && (dcnt == 6'd33);
        hold = stall || (is_div && !rdy);
        case (forward_a)
            exe_pkg::from_mem: a = exp_q.result;
            exe_pkg::from_wb:  a = result_w;
            default:           a = cur.srca;
        endcase
        case (forward_b)
            exe_pkg::from_mem: fb = exp_q.result;
            exe_pkg::from_wb:  fb = result_w;
            default:           fb = cur.srcb;
        endcase
        b   = cur.use_imm ? cur.imm : fb;
        ovf = calc_ovf(cur.alu_op, a, b);
        nxt = '0;
        if (!hold) begin
            nxt.result    = calc_result(cur.alu_op, a, b, cur.sa, cur.pc, hilo_q);
            nxt.mem_wdata = fb;
            nxt.writereg  = cur.link ? 5'd31 : (cur.dst_rd ? cur.rd : cur.rt);
            nxt.reg_write = cur.reg_write && !ovf;
            nxt.mem_read  = cur.mem_read;
            nxt.mem_write = cur.mem_write;
            nxt.overflow  = ovf;
        end
        pa       = $signed(a);
        pb       = $signed(b);
        hl_wr    = 1'b1;
        hilo_nxt = hilo_q;
        case (cur.alu_op)
            exe_pkg::mult:  hilo_nxt = pa * pb;
            exe_pkg::multu: hilo_nxt = {32'd0, a} * {32'd0, b};
            exe_pkg::mthi:  hilo_nxt = {a, hilo_q[31:0]};
            exe_pkg::mtlo:  hilo_nxt = {hilo_q[63:32], a};
            exe_pkg::div:   hilo_nxt = calc_div(1'b1, a, b);
            exe_pkg::divu:  hilo_nxt = calc_div(1'b0, a, b);
            default:        hl_wr = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cur    <= bubble;
            dcnt   <= '0;
            exp_q  <= '0;
            hilo_q <= '0;
        end else begin
            exp_q <= nxt;
            if (hl_wr && !hold) begin
                hilo_q <= hilo_nxt;
            end
            if (flush) begin
                cur  <= bubble;
                dcnt <= '0;
            end else if (!hold) begin
                cur  <= id_in;
                dcnt <= '0;
            end else if (is_div && !rdy) begin
                dcnt <= dcnt + 6'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // assertions
    //////////////////////////////////////////////////

    a_result: assert property (@(posedge clk) disable iff (!resetn)
        ex_mem.result == exp_q.result)
        else begin
            errors = errors + 1;
            $error("Fail %0t: result %h, expected %h", $time, ex_mem.result, exp_q.result);
        end

    a_wdata: assert property (@(posedge clk) disable iff (!resetn)
        ex_mem.mem_wdata == exp_q.mem_wdata)
        else begin
            errors = errors + 1;
            $error("Fail %0t: store data %h, expected %h", $time, ex_mem.mem_wdata,
                   exp_q.mem_wdata);
        end

    a_dest: assert property (@(posedge clk) disable iff (!resetn)
        ex_mem.writereg == exp_q.writereg)
        else begin
            errors = errors + 1;
            $error("Fail %0t: writereg %0d, expected %0d", $time, ex_mem.writereg,
                   exp_q.writereg);
        end

    a_ctrl: assert property (@(posedge clk) disable iff (!resetn)
        {ex_mem.reg_write, ex_mem.mem_read, ex_mem.mem_write, ex_mem.overflow} ==
        {exp_q.reg_write, exp_q.mem_read, exp_q.mem_write, exp_q.overflow})
        else begin
            errors = errors + 1;
            $error("Fail %0t: control bits of ex_mem differ from expected", $time);
        end

    a_hilo: assert property (@(posedge clk) disable iff (!resetn) hilo == hilo_q)
        else begin
            errors = errors + 1;
            $error("Fail %0t: hilo %h, expected %h", $time, hilo, hilo_q);
        end

    a_busy: assert property (@(posedge clk) disable iff (!resetn) busy == (is_div && !rdy))
        else begin
            errors = errors + 1;
            $error("Fail %0t: busy %b, expected %b", $time, busy, is_div && !rdy);
        end

    // held cycles retire bubbles and leave hi/lo alone
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        $past(hold) |->
        (!(ex_mem.reg_write || ex_mem.mem_read || ex_mem.mem_write) && hilo == $past(hilo)))
        else begin
            errors = errors + 1;
            $error("Fail %0t: held cycle let control bits or a hilo write through", $time);
        end

    a_flush: assert property (@(posedge clk) disable iff (!resetn)
        $past(flush, 2) |-> !(ex_mem.reg_write || ex_mem.mem_read || ex_mem.mem_write))
        else begin
            errors = errors + 1;
            $error("Fail %0t: flushed slot reached ex_mem with control bits", $time);
        end

endmodule

bind exe_core exe_core_sva #(.reset_pc(reset_pc)) u_chk (.*);

/* bench/exe_core_tb.sv */
module exe_core_tb;

    localparam int N_RAND = 400;
    localparam int N_DIV  = 10;
    // one cycle per random op and 34 edges per divide, with room to spare
    localparam int LIMIT  = N_RAND * 3 + N_DIV * 40 + 300;

    logic              clk;
    logic              resetn;
    logic              stall;
    logic              flush;
    exe_pkg::id_ex_t   id_in;
    exe_pkg::fwd_sel_e forward_a;
    exe_pkg::fwd_sel_e forward_b;
    exe_pkg::word_t    result_w;
    exe_pkg::ex_mem_t  ex_mem;
    exe_pkg::dword_t   hilo;
    logic              busy;

    int unsigned rng = 98165;
    int          cycles = 0;

    exe_core #(
        .reset_pc (32'hbfc00000)
    ) uut (
        .clk       (clk),
        .resetn    (resetn),
        .stall     (stall),
        .flush     (flush),
        .id_in     (id_in),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .result_w  (result_w),
        .ex_mem    (ex_mem),
        .hilo      (hilo),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function int unsigned lcg();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function exe_pkg::fwd_sel_e random_fwd();
        int unsigned r;
        r = lcg() % 3;
        if (r == 0) return exe_pkg::reg_file;
        if (r == 1) return exe_pkg::from_mem;
        return exe_pkg::from_wb;
    endfunction

    // any operation except the divides
    function exe_pkg::alu_op_e random_op();
        exe_pkg::alu_op_e op;
        op = exe_pkg::alu_op_e'(5'(lcg() % 27));
        if (op == exe_pkg::div || op == exe_pkg::divu) begin
            op = exe_pkg::add;
        end
        return op;
    endfunction

    function exe_pkg::id_ex_t make_instr(input exe_pkg::alu_op_e op);
        exe_pkg::id_ex_t ins;
        int unsigned     bits;
        bits          = lcg();
        ins.pc        = lcg() & 32'hfffffffc;
        ins.srca      = lcg();
        ins.srcb      = lcg();
        ins.imm       = lcg();
        ins.rs        = bits[4:0];
        ins.rt        = bits[9:5];
        ins.rd        = bits[14:10];
        ins.sa        = bits[19:15];
        ins.alu_op    = op;
        ins.reg_write = 1'b1;
        ins.use_imm   = bits[20];
        ins.dst_rd    = bits[21];
        ins.link      = (op == exe_pkg::link);
        ins.mem_read  = bits[22];
        ins.mem_write = bits[23];
        return ins;
    endfunction

    task send(input exe_pkg::id_ex_t ins, input exe_pkg::fwd_sel_e fa,
              input exe_pkg::fwd_sel_e fb, input logic st, input logic fl);
        @(posedge clk);
        id_in     <= ins;
        forward_a <= fa;
        forward_b <= fb;
        stall     <= st;
        flush     <= fl;
        result_w  <= lcg();
    endtask

    task send_regs(input exe_pkg::alu_op_e op, input exe_pkg::word_t x,
                   input exe_pkg::word_t y);
        exe_pkg::id_ex_t ins;
        ins         = make_instr(op);
        ins.srca    = x;
        ins.srcb    = y;
        ins.use_imm = 1'b0;
        send(ins, exe_pkg::reg_file, exe_pkg::reg_file, 1'b0, 1'b0);
    endtask

    // divide and wait out busy before reading both halves back
    task run_div(input logic sgn, input exe_pkg::word_t n, input exe_pkg::word_t d);
        send_regs(sgn ? exe_pkg::div : exe_pkg::divu, n, d);
        send_regs(exe_pkg::nop, 32'd0, 32'd0);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        send_regs(exe_pkg::mfhi, 32'd0, 32'd0);
        send_regs(exe_pkg::mflo, 32'd0, 32'd0);
    endtask

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (uut.u_chk.errors != 0) begin
            $display("checker assertion failed at time %0t", $time);
            $display("Some tests failed");
            $fatal(1);
        end else if (cycles > LIMIT) begin
            $display("timeout after %0d cycles", LIMIT);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    initial begin
        resetn    = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        id_in     = '0;
        forward_a = exe_pkg::reg_file;
        forward_b = exe_pkg::reg_file;
        result_w  = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        ////////////////////////////////////////////////
        // directed sequences
        ////////////////////////////////////////////////
        send_regs(exe_pkg::add, 32'h7fffffff, 32'd1);
        send_regs(exe_pkg::sub, 32'h80000000, 32'd1);
        send_regs(exe_pkg::addu, 32'h7fffffff, 32'd1);
        send_regs(exe_pkg::subu, 32'h80000000, 32'd1);
        send_regs(exe_pkg::mult, 32'hfffffffd, 32'd7);
        send_regs(exe_pkg::mfhi, 32'd0, 32'd0);
        send_regs(exe_pkg::mflo, 32'd0, 32'd0);
        send_regs(exe_pkg::multu, 32'hfffffffd, 32'd7);
        send_regs(exe_pkg::mthi, 32'h12345678, 32'd0);
        send_regs(exe_pkg::mtlo, 32'h9abcdef0, 32'd0);
        send_regs(exe_pkg::mfhi, 32'd0, 32'd0);
        send_regs(exe_pkg::mflo, 32'd0, 32'd0);
        send(make_instr(exe_pkg::or_op), exe_pkg::from_mem, exe_pkg::from_wb, 1'b0, 1'b0);
        send(make_instr(exe_pkg::add), exe_pkg::from_wb, exe_pkg::from_mem, 1'b0, 1'b0);
        send(make_instr(exe_pkg::link), exe_pkg::reg_file, exe_pkg::reg_file, 1'b0, 1'b1);
        // mult sits in execute while a one-cycle stall holds it
        send_regs(exe_pkg::mult, 32'h00012345, 32'hfff00001);
        send(make_instr(exe_pkg::nop), exe_pkg::reg_file, exe_pkg::reg_file, 1'b1, 1'b0);

        run_div(1'b1, 32'd100, 32'd7);
        run_div(1'b1, 32'hffffff9c, 32'd7);
        run_div(1'b1, 32'd100, 32'hfffffff9);
        run_div(1'b1, 32'h80000000, 32'hffffffff);
        run_div(1'b1, 32'hfffffff0, 32'd0);
        run_div(1'b0, 32'hffffff9c, 32'd7);
        run_div(1'b0, 32'd1234, 32'd0);
        run_div(1'b0, lcg(), lcg() >> 8);
        run_div(1'b1, lcg(), lcg() >> 12);
        run_div(1'b1, lcg(), lcg());

        ////////////////////////////////////////////////
        // random stream
        ////////////////////////////////////////////////
        for (int i = 0; i < N_RAND; i++) begin
            send(make_instr(random_op()), random_fwd(), random_fwd(),
                 (lcg() % 10) == 0, (lcg() % 20) == 0);
        end

        // drain the pipeline
        repeat (4) send_regs(exe_pkg::nop, 32'd0, 32'd0);
        repeat (3) @(posedge clk);
        @(negedge clk);

        if (uut.u_chk.errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

/* flist.f */
rtl/exe_pkg.sv
rtl/exe_stage.sv
rtl/exe_alu.sv
rtl/div_unit.sv
rtl/retire_stage.sv
rtl/exe_core.sv
bench/exe_core_sva.sv
bench/exe_core_tb.sv

/* rtl/div_unit.sv */
module div_unit (
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    input  logic            is_signed,
    input  exe_pkg::word_t  dividend,
    input  exe_pkg::word_t  divisor,
    output logic            ready,
    output exe_pkg::dword_t result
);

    typedef enum logic [1:0] {
        idle,
        run,
        done
    } state_e;

    state_e         state;
    logic [4:0]     count;
    exe_pkg::word_t quo;
    exe_pkg::word_t rem;
    exe_pkg::word_t dvsr;
    logic           neg_q;
    logic           neg_r;
    logic           by_zero;
    logic [32:0]    shifted;
    logic [32:0]    diff;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= idle;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        count <= '0;
                    end
                end
                run: begin
                    count <= count + 5'd1;
                    // 32 quotient bits
                    if (count == 5'd31) begin
                        state <= done;
                    end
                end
                done:    state <= idle;
                default: state <= idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // shift and subtract datapath
    //////////////////////////////////////////////////

    // next remainder bit comes from the top of the quotient register
    assign shifted = {rem, quo[31]};
    assign diff    = shifted - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            // work on magnitudes, signs applied at the end
            quo     <= (is_signed && dividend[31]) ? -dividend : dividend;
            dvsr    <= (is_signed && divisor[31]) ? -divisor : divisor;
            rem     <= '0;
            neg_q   <= is_signed && (dividend[31] ^ divisor[31]);
            neg_r   <= is_signed && dividend[31];
            by_zero <= (divisor == '0);
        end else if (state == run) begin
            if (!diff[32]) begin
                rem <= diff[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= shifted[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    assign ready = (state == done);

    // remainder in hi, quotient in lo
    // zero divisor leaves the dividend in rem after the sign fix
    assign result[63:32] = neg_r ? -rem : rem;
    assign result[31:0]  = by_zero ? '1 : (neg_q ? -quo : quo);

endmodule

/* rtl/exe_alu.sv */
module exe_alu (
    input  exe_pkg::alu_op_e   alu_op,
    input  exe_pkg::word_t     op_a,
    input  exe_pkg::word_t     op_b,
    input  exe_pkg::reg_addr_t shamt,
    input  exe_pkg::word_t     pc,
    input  exe_pkg::dword_t    hilo,
    input  exe_pkg::dword_t    div_result,
    input  logic               div_ready,
    output exe_pkg::word_t     result,
    output logic               overflow,
    output exe_pkg::dword_t    hilo_next,
    output logic               hilo_write
);

    exe_pkg::word_t  b_eff;
    exe_pkg::word_t  sum;
    exe_pkg::dword_t prod_s;
    exe_pkg::dword_t prod_u;
    logic            is_sub;

    //////////////////////////////////////////////////
    // adder and multiplier
    //////////////////////////////////////////////////

    assign is_sub = (alu_op == exe_pkg::sub) || (alu_op == exe_pkg::subu);
    assign b_eff  = is_sub ? ~op_b : op_b;
    assign sum    = op_a + b_eff + {31'd0, is_sub};

    // operands of same sign, result of the other
    assign overflow = ((alu_op == exe_pkg::add) || (alu_op == exe_pkg::sub)) &&
                      (op_a[31] == b_eff[31]) && (sum[31] != op_a[31]);

    // sign extended to 64 bits, low half of the product is exact
    assign prod_s = {{32{op_a[31]}}, op_a} * {{32{op_b[31]}}, op_b};
    assign prod_u = {32'd0, op_a} * {32'd0, op_b};

    //////////////////////////////////////////////////
    // result mux
    //////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            exe_pkg::and_op: result = op_a & op_b;
            exe_pkg::or_op:  result = op_a | op_b;
            exe_pkg::xor_op: result = op_a ^ op_b;
            exe_pkg::nor_op: result = ~(op_a | op_b);
            exe_pkg::lui:    result = {op_b[15:0], 16'd0};
            exe_pkg::sll:    result = op_b << shamt;
            exe_pkg::srl:    result = op_b >> shamt;
            exe_pkg::sra:    result = $signed(op_b) >>> shamt;
            exe_pkg::sllv:   result = op_b << op_a[4:0];
            exe_pkg::srlv:   result = op_b >> op_a[4:0];
            exe_pkg::srav:   result = $signed(op_b) >>> op_a[4:0];
            exe_pkg::add, exe_pkg::addu,
            exe_pkg::sub, exe_pkg::subu:
                             result = sum;
            exe_pkg::slt:    result = {31'd0, $signed(op_a) < $signed(op_b)};
            exe_pkg::sltu:   result = {31'd0, op_a < op_b};
            exe_pkg::mfhi:   result = hilo[63:32];
            exe_pkg::mflo:   result = hilo[31:0];
            // return address skips the delay slot
            exe_pkg::link:   result = pc + 32'd8;
            default:         result = '0;
        endcase
    end

    // next hi/lo value and its write enable
    always_comb begin
        hilo_next  = hilo;
        hilo_write = 1'b0;
        case (alu_op)
            exe_pkg::mult: begin
                hilo_next  = prod_s;
                hilo_write = 1'b1;
            end
            exe_pkg::multu: begin
                hilo_next  = prod_u;
                hilo_write = 1'b1;
            end
            exe_pkg::mthi: begin
                hilo_next  = {op_a, hilo[31:0]};
                hilo_write = 1'b1;
            end
            exe_pkg::mtlo: begin
                hilo_next  = {hilo[63:32], op_a};
                hilo_write = 1'b1;
            end
            exe_pkg::div, exe_pkg::divu: begin
                hilo_next  = div_result;
                hilo_write = div_ready;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/exe_core.sv */
module exe_core #(
    parameter exe_pkg::word_t reset_pc = 32'hbfc00000
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              stall,
    input  logic              flush,
    input  exe_pkg::id_ex_t   id_in,
    input  exe_pkg::fwd_sel_e forward_a,
    input  exe_pkg::fwd_sel_e forward_b,
    input  exe_pkg::word_t    result_w,
    output exe_pkg::ex_mem_t  ex_mem,
    output exe_pkg::dword_t   hilo,
    output logic              busy
);

    exe_pkg::alu_op_e   alu_op;
    exe_pkg::word_t     op_a;
    exe_pkg::word_t     op_b;
    exe_pkg::reg_addr_t shamt;
    exe_pkg::word_t     pc;
    exe_pkg::word_t     alu_result;
    logic               overflow;
    exe_pkg::dword_t    hilo_next;
    logic               hilo_write;
    logic               div_start;
    logic               div_signed;
    exe_pkg::word_t     dividend;
    exe_pkg::word_t     divisor;
    logic               div_ready;
    exe_pkg::dword_t    div_result;
    logic               advance;
    exe_pkg::ex_mem_t   ex_out;

    exe_stage #(
        .reset_pc (reset_pc)
    ) u_exe_stage (
        .clk        (clk),
        .resetn     (resetn),
        .stall      (stall),
        .flush      (flush),
        .id_in      (id_in),
        .forward_a  (forward_a),
        .forward_b  (forward_b),
        .result_m   (ex_mem.result),
        .result_w   (result_w),
        .alu_result (alu_result),
        .overflow   (overflow),
        .div_ready  (div_ready),
        .alu_op     (alu_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .shamt      (shamt),
        .pc         (pc),
        .div_start  (div_start),
        .div_signed (div_signed),
        .dividend   (dividend),
        .divisor    (divisor),
        .advance    (advance),
        .busy       (busy),
        .ex_out     (ex_out)
    );

    exe_alu u_exe_alu (
        .alu_op     (alu_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .shamt      (shamt),
        .pc         (pc),
        .hilo       (hilo),
        .div_result (div_result),
        .div_ready  (div_ready),
        .result     (alu_result),
        .overflow   (overflow),
        .hilo_next  (hilo_next),
        .hilo_write (hilo_write)
    );

    div_unit u_div_unit (
        .clk       (clk),
        .resetn    (resetn),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (dividend),
        .divisor   (divisor),
        .ready     (div_ready),
        .result    (div_result)
    );

    retire_stage u_retire_stage (
        .clk        (clk),
        .resetn     (resetn),
        .advance    (advance),
        .ex_in      (ex_out),
        .hilo_next  (hilo_next),
        .hilo_write (hilo_write),
        .ex_mem     (ex_mem),
        .hilo       (hilo)
    );

endmodule

/* rtl/exe_pkg.sv */
package exe_pkg;

    //////////////////////////////////////////////////
    // basic widths
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    // hi in the upper half, lo in the lower half
    typedef logic [63:0] dword_t;
    // register number, also the shift amount
    typedef logic [4:0]  reg_addr_t;

    //////////////////////////////////////////////////
    // operation codes
    //////////////////////////////////////////////////

    typedef enum logic [4:0] {
        nop, and_op, or_op, xor_op, nor_op, lui,
        sll, srl, sra, sllv, srlv, srav,
        add, addu, sub, subu, slt, sltu,
        mult, multu, div, divu,
        mthi, mtlo, mfhi, mflo,
        link
    } alu_op_e;

    // operand source picked by the hazard logic
    typedef enum logic [1:0] {
        reg_file = 2'b00,
        from_wb  = 2'b01,
        from_mem = 2'b10
    } fwd_sel_e;

    //////////////////////////////////////////////////
    // stage bundles
    //////////////////////////////////////////////////

    // decode to execute
    typedef struct packed {
        word_t     pc;
        word_t     srca;
        word_t     srcb;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        reg_addr_t sa;
        alu_op_e   alu_op;
        logic      reg_write;
        logic      use_imm;
        // write rd instead of rt
        logic      dst_rd;
        // write register 31
        logic      link;
        logic      mem_read;
        logic      mem_write;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        word_t     result;
        word_t     mem_wdata;
        reg_addr_t writereg;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      overflow;
    } ex_mem_t;

endpackage

/* rtl/exe_stage.sv */
module exe_stage #(
    parameter exe_pkg::word_t reset_pc = 32'hbfc00000
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               stall,
    input  logic               flush,
    input  exe_pkg::id_ex_t    id_in,
    input  exe_pkg::fwd_sel_e  forward_a,
    input  exe_pkg::fwd_sel_e  forward_b,
    input  exe_pkg::word_t     result_m,
    input  exe_pkg::word_t     result_w,
    input  exe_pkg::word_t     alu_result,
    input  logic               overflow,
    input  logic               div_ready,
    output exe_pkg::alu_op_e   alu_op,
    output exe_pkg::word_t     op_a,
    output exe_pkg::word_t     op_b,
    output exe_pkg::reg_addr_t shamt,
    output exe_pkg::word_t     pc,
    output logic               div_start,
    output logic               div_signed,
    output exe_pkg::word_t     dividend,
    output exe_pkg::word_t     divisor,
    output logic               advance,
    output logic               busy,
    output exe_pkg::ex_mem_t   ex_out
);

    exe_pkg::id_ex_t   id_r;
    exe_pkg::id_ex_t   bubble;
    exe_pkg::word_t    fwd_b;
    exe_pkg::reg_addr_t dst;
    logic              is_div;
    logic              div_hold;
    logic              hold;

    // empty slot written on reset and flush
    always_comb begin
        bubble        = '0;
        bubble.pc     = reset_pc;
        bubble.alu_op = exe_pkg::nop;
    end

    //////////////////////////////////////////////////
    // decode/execute register
    //////////////////////////////////////////////////

    // flush wins over a hold
    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            id_r <= bubble;
        end else if (!hold) begin
            id_r <= id_in;
        end
    end

    //////////////////////////////////////////////////
    // divider control
    //////////////////////////////////////////////////

    assign is_div   = (id_r.alu_op == exe_pkg::div) || (id_r.alu_op == exe_pkg::divu);
    // wait until the divider returns its one-cycle ready
    assign div_hold = is_div && !div_ready;
    assign hold     = stall || div_hold;

    assign div_start  = div_hold;
    assign div_signed = (id_r.alu_op == exe_pkg::div);
    assign dividend   = op_a;
    assign divisor    = op_b;

    assign advance = !hold;
    assign busy    = div_hold;

    //////////////////////////////////////////////////
    // operand forwarding
    //////////////////////////////////////////////////

    always_comb begin
        case (forward_a)
            exe_pkg::from_mem: op_a = result_m;
            exe_pkg::from_wb:  op_a = result_w;
            default:           op_a = id_r.srca;
        endcase
    end

    // store data follows the b select too
    always_comb begin
        case (forward_b)
            exe_pkg::from_mem: fwd_b = result_m;
            exe_pkg::from_wb:  fwd_b = result_w;
            default:           fwd_b = id_r.srcb;
        endcase
    end

    assign op_b   = id_r.use_imm ? id_r.imm : fwd_b;
    assign alu_op = id_r.alu_op;
    assign shamt  = id_r.sa;
    assign pc     = id_r.pc;

    // link always writes r31
    assign dst = id_r.link   ? 5'd31 :
                 id_r.dst_rd ? id_r.rd : id_r.rt;

    always_comb begin
        ex_out.result    = alu_result;
        ex_out.mem_wdata = fwd_b;
        ex_out.writereg  = dst;
        // an overflowing add/sub must not reach the register file
        ex_out.reg_write = id_r.reg_write && !overflow;
        ex_out.mem_read  = id_r.mem_read;
        ex_out.mem_write = id_r.mem_write;
        ex_out.overflow  = overflow;
    end

endmodule

/* rtl/retire_stage.sv */
module retire_stage (
    input  logic             clk,
    input  logic             resetn,
    input  logic             advance,
    input  exe_pkg::ex_mem_t ex_in,
    input  exe_pkg::dword_t  hilo_next,
    input  logic             hilo_write,
    output exe_pkg::ex_mem_t ex_mem,
    output exe_pkg::dword_t  hilo
);

    //////////////////////////////////////////////////
    // execute/memory register
    //////////////////////////////////////////////////

    // bubble whenever execute is held
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_mem <= '0;
        end else if (advance) begin
            ex_mem <= ex_in;
        end else begin
            ex_mem <= '0;
        end
    end

    //////////////////////////////////////////////////
    // hi/lo register
    //////////////////////////////////////////////////

    // commits only when the writing instruction leaves execute
    always_ff @(posedge clk) begin
        if (!resetn) begin
            hilo <= '0;
        end else if (advance && hilo_write) begin
            hilo <= hilo_next;
        end
    end

endmodule
